//--- src/gfx_pkg.sv
//==========================================================
// Graphics types
// Pixel coordinates, triangle vertices and RGB colour
// shared by the span-fill blocks
//==========================================================
package gfx_pkg;

	// width of one RGB pixel
	localparam int COLOR_W = 24;

	// one 8-bit screen coordinate
	typedef logic [7:0] coord_t;

	// y sits in the upper byte, x in the lower byte
	typedef struct packed {
		coord_t y;
		coord_t x;
	} vertex_t;

	// vertex 0 in the low 16 bits
	typedef vertex_t [2:0] tri_t;

	// 8 bits each of red, green and blue
	typedef logic [COLOR_W-1:0] color_t;

endpackage

//--- src/sram_pkg.sv
//==========================================================
// SRAM map
// Word address type and the layer buffer layout
//==========================================================
package sram_pkg;

	typedef logic [23:0] addr_t;

	localparam addr_t LAYER0_BASE = 24'd0;
	localparam addr_t LAYER1_BASE = 24'd65536;

	// one screen line apart
	localparam addr_t ROW_STRIDE = 24'd256;

	// start of the selected layer buffer
	function automatic addr_t layer_base(input logic layer);
		if (layer)
			return LAYER1_BASE;
		return LAYER0_BASE;
	endfunction

endpackage

//--- src/sram_if.sv
//==========================================================
// SRAM port bundle
// Read and write strobes, word address and row-wide data
//==========================================================
`timescale 1ns/1ps

interface sram_if
	import gfx_pkg::*, sram_pkg::*;
#(
	parameter int PIXELS = 64
)
();
	logic read_enable;
	logic write_enable;
	addr_t address;
	// one word holds a full row of pixels
	color_t [PIXELS-1:0] write_data;
	color_t [PIXELS-1:0] read_data;

	modport master (
		output read_enable, write_enable, address, write_data,
		input read_data
	);

	modport memory (
		input read_enable, write_enable, address, write_data,
		output read_data
	);
endinterface

//--- src/bbox_corner.sv
//==========================================================
// Bounding-box corner
// Registers the smallest x and y over the three vertices
// of the incoming triangle
//==========================================================
`timescale 1ns/1ps

module bbox_corner
	import gfx_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic math_start,
	input tri_t vertices,
	output coord_t xmin,
	output coord_t ymin
);
	coord_t x_lo;
	coord_t y_lo;

	always_comb
	begin
		x_lo = vertices[0].x;
		y_lo = vertices[0].y;
		for (int v = 1; v < 3; v++)
		begin
			if (vertices[v].x < x_lo)
				x_lo = vertices[v].x;
			if (vertices[v].y < y_lo)
				y_lo = vertices[v].y;
		end
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			xmin <= '0;
			ymin <= '0;
		end
		else if (math_start)
		begin
			xmin <= x_lo;
			ymin <= y_lo;
		end
	end
endmodule

//--- src/row_address.sv
//==========================================================
// Row address generator
// Counts finished rows and tracks the SRAM word address
// of the row being filled
//==========================================================
`timescale 1ns/1ps

module row_address
	import gfx_pkg::*, sram_pkg::*;
#(
	parameter int ROWS = 64
)
(
	input logic clk,
	input logic n_rst,
	input logic math_start,
	input logic layer_num,
	input logic row_advance,
	input coord_t xmin,
	input coord_t ymin,
	output addr_t address,
	output logic [$clog2(ROWS+1)-1:0] row_index,
	output logic all_finish
);
	// corner is registered on the math_start edge, so load one cycle later
	logic load_pending;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			load_pending <= 1'b0;
			row_index <= '0;
			address <= '0;
		end
		else
		begin
			load_pending <= math_start;
			if (math_start)
				row_index <= '0;
			else if (row_advance)
				row_index <= row_index + 1'b1;

			if (load_pending)
				address <= layer_base(layer_num) + addr_t'(ymin) * ROW_STRIDE + addr_t'(xmin);
			else if (row_advance)
				address <= address + ROW_STRIDE;
		end
	end

	assign all_finish = (row_index == ROWS);
endmodule

//--- src/span_fill.sv
//==========================================================
// Span fill
// Per-row FSM: reads the row word, paints the covered span
// with the colour and writes the word back
//==========================================================
`timescale 1ns/1ps

module span_fill
	import gfx_pkg::*, sram_pkg::*;
#(
	parameter int PIXELS = 64,
	parameter int ROWS = 64
)
(
	input logic clk,
	input logic n_rst,
	input logic fill_start,
	input color_t color,
	input logic [ROWS-1:0][PIXELS-1:0] mask,
	input logic [$clog2(ROWS+1)-1:0] row_index,
	input addr_t row_addr,
	input logic all_finish,
	output logic fill_done,
	output logic row_advance,
	sram_if.master mem
);
	localparam int PIX_W = $clog2(PIXELS);

	typedef enum logic [2:0] {
		IDLE,
		READ,
		CAPTURE,
		WRITE,
		DONE
	} state_t;

	state_t state;
	state_t next_state;

	logic [PIXELS-1:0] row_mask;
	logic [PIX_W-1:0] first_pix;
	logic [PIX_W-1:0] last_pix;
	logic span_found;
	color_t [PIXELS-1:0] painted;
	color_t [PIXELS-1:0] painted_q;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (fill_start && !all_finish)
					next_state = READ;
			end
			READ: next_state = CAPTURE;
			CAPTURE: next_state = WRITE;
			WRITE: next_state = DONE;
			DONE: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	assign row_mask = mask[row_index];
	assign span_found = |row_mask;

	// lowest set bit wins, scanning down
	always_comb
	begin
		first_pix = '0;
		for (int p = PIXELS - 1; p >= 0; p--)
		begin
			if (row_mask[p])
				first_pix = PIX_W'(p);
		end
	end

	// highest set bit wins, scanning up
	always_comb
	begin
		last_pix = '0;
		for (int p = 0; p < PIXELS; p++)
		begin
			if (row_mask[p])
				last_pix = PIX_W'(p);
		end
	end

	// inclusive span gets the colour, the rest keeps the SRAM contents
	always_comb
	begin
		for (int p = 0; p < PIXELS; p++)
		begin
			if (span_found && p >= first_pix && p <= last_pix)
				painted[p] = color;
			else
				painted[p] = mem.read_data[p];
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == CAPTURE)
			painted_q <= painted;
	end

	assign mem.read_enable = (state == READ);
	assign mem.write_enable = (state == WRITE);
	assign mem.address = (state == READ || state == WRITE) ? row_addr : '0;
	assign mem.write_data = painted_q;

	assign fill_done = (state == DONE);
	assign row_advance = (state == DONE);
endmodule

//--- src/gfx_fill_top.sv
//==========================================================
// Span-fill stage top level
// Corner finder, row address generator and span fill
// joined to plain control and SRAM ports
//==========================================================
`timescale 1ns/1ps

module gfx_fill_top
	import gfx_pkg::*, sram_pkg::*;
#(
	parameter int PIXELS = 64,
	parameter int ROWS = 64
)
(
	input logic clk,
	input logic n_rst,
	input logic math_start,
	input logic fill_start,
	input logic layer_num,
	input tri_t vertices,
	input color_t color,
	input logic [ROWS*PIXELS-1:0] mask,
	output logic fill_done,
	output logic all_finish,
	output logic read_enable,
	output logic write_enable,
	output addr_t address,
	input color_t [PIXELS-1:0] read_data,
	output color_t [PIXELS-1:0] write_data
);
	coord_t xmin;
	coord_t ymin;
	addr_t row_addr;
	logic [$clog2(ROWS+1)-1:0] row_index;
	logic row_advance;

	sram_if #(.PIXELS(PIXELS)) mem_bus ();

	assign read_enable = mem_bus.read_enable;
	assign write_enable = mem_bus.write_enable;
	assign address = mem_bus.address;
	assign write_data = mem_bus.write_data;
	assign mem_bus.read_data = read_data;

	bbox_corner u_bbox_corner (
		.clk(clk),
		.n_rst(n_rst),
		.math_start(math_start),
		.vertices(vertices),
		.xmin(xmin),
		.ymin(ymin)
	);

	row_address #(.ROWS(ROWS)) u_row_address (
		.clk(clk),
		.n_rst(n_rst),
		.math_start(math_start),
		.layer_num(layer_num),
		.row_advance(row_advance),
		.xmin(xmin),
		.ymin(ymin),
		.address(row_addr),
		.row_index(row_index),
		.all_finish(all_finish)
	);

	span_fill #(.PIXELS(PIXELS), .ROWS(ROWS)) u_span_fill (
		.clk(clk),
		.n_rst(n_rst),
		.fill_start(fill_start),
		.color(color),
		.mask(mask),
		.row_index(row_index),
		.row_addr(row_addr),
		.all_finish(all_finish),
		.fill_done(fill_done),
		.row_advance(row_advance),
		.mem(mem_bus.master)
	);
endmodule

//--- sim/tb_fill_model.svh
//==========================================================
// Span-fill reference model
// Expected row address and painted word, with typed
// compare tasks for addresses, words and flags
//==========================================================
`ifndef TB_FILL_MODEL_SVH
`define TB_FILL_MODEL_SVH

function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
	coord_t m;
	m = a;
	if (b < m)
		m = b;
	if (c < m)
		m = c;
	return m;
endfunction

// layer base plus corner offset plus one stride per row
function automatic addr_t expected_addr(input tri_t tv, input logic layer, input int row);
	addr_t base;
	base = layer ? LAYER1_BASE : LAYER0_BASE;
	base = base + ROW_STRIDE * addr_t'(min3(tv[0].y, tv[1].y, tv[2].y));
	return base + addr_t'(min3(tv[0].x, tv[1].x, tv[2].x)) + ROW_STRIDE * addr_t'(row);
endfunction

// inclusive span from the first to the last covered pixel
function automatic word_t paint_row(input word_t old, input logic [PIXELS-1:0] bits,
		input color_t c);
	word_t w;
	int lo;
	int hi;
	w = old;
	lo = -1;
	hi = -1;
	for (int p = 0; p < PIXELS; p++)
	begin
		if (bits[p])
		begin
			if (lo < 0)
				lo = p;
			hi = p;
		end
	end
	for (int p = 0; p < PIXELS; p++)
	begin
		if (lo >= 0 && p >= lo && p <= hi)
			w[p] = c;
	end
	return w;
endfunction

task automatic note_failure(input string msg);
	errors++;
	$display("%s", msg);
endtask

task automatic check_addr(input string name, input addr_t exp_v, input addr_t got);
	checks++;
	if (got !== exp_v)
		note_failure($sformatf("error %s: expected %h, got %h", name, exp_v, got));
endtask

task automatic check_word(input string name, input word_t exp_v, input word_t got);
	checks++;
	if (got !== exp_v)
		note_failure($sformatf("error %s: expected %h, got %h", name, exp_v, got));
endtask

task automatic check_flag(input string name, input logic exp_v, input logic got);
	checks++;
	if (got !== exp_v)
		note_failure($sformatf("error %s: expected %h, got %h", name, exp_v, got));
endtask

`endif

//--- sim/tb_gfx_fill.sv
//==========================================================
// Span-fill stage testbench
// Random triangles into a modelled SRAM, checked against
// the reference model, with a watchdog
//==========================================================
`timescale 1ns/1ps

module tb_gfx_fill
	import gfx_pkg::*, sram_pkg::*;
();
	localparam int PIXELS = 64;
	localparam int ROWS = 8;
	localparam int TRIS = 20;
	localparam int WATCHDOG_CYCLES = TRIS * (ROWS * 6 + 10) + 100;

	typedef color_t [PIXELS-1:0] word_t;

	logic clk;
	logic n_rst;
	logic math_start;
	logic fill_start;
	logic layer_num;
	tri_t vertices;
	color_t color;
	logic [ROWS*PIXELS-1:0] mask;
	logic fill_done;
	logic all_finish;
	logic read_enable;
	logic write_enable;
	addr_t address;
	word_t read_data;
	word_t write_data;

	int errors;
	int checks;
	int reads;
	int writes;
	int cur_row;
	addr_t exp_addr;
	word_t exp_word;
	word_t fill_word;
	word_t sram [addr_t];

	gfx_fill_top #(.PIXELS(PIXELS), .ROWS(ROWS)) u_gfx_fill_top (.*);

	`include "tb_fill_model.svh"

	always #10 clk = ~clk;

	function automatic word_t random_word();
		word_t w;
		for (int p = 0; p < PIXELS; p++)
			w[p] = color_t'($urandom);
		return w;
	endfunction

	// mostly empty, single-bit or full rows
	function automatic logic [PIXELS-1:0] random_row();
		logic [PIXELS-1:0] bits;
		bits = '0;
		case ($urandom_range(4, 0))
			0: bits = '0;
			1: bits[$urandom_range(PIXELS - 1, 0)] = 1'b1;
			2: bits = '1;
			default: bits = {$urandom, $urandom};
		endcase
		return bits;
	endfunction

	// SRAM with one cycle of read latency
	always @(posedge clk)
	begin
		if (read_enable)
		begin
			if (!sram.exists(address))
				sram[address] = fill_word;
			reads++;
			check_addr("read address", exp_addr, address);
			read_data <= sram[address];
			exp_word = paint_row(sram[address], mask[cur_row*PIXELS +: PIXELS], color);
		end
		if (write_enable)
		begin
			writes++;
			check_addr("write address", exp_addr, address);
			check_word("write_data", exp_word, write_data);
			sram[address] = write_data;
		end
	end

	task automatic check_idle();
		check_flag("read_enable", 1'b0, read_enable);
		check_flag("write_enable", 1'b0, write_enable);
		check_flag("fill_done", 1'b0, fill_done);
		check_flag("all_finish", 1'b0, all_finish);
	endtask

	task automatic start_triangle();
		@(posedge clk);
		math_start <= 1'b1;
		vertices <= 48'({$urandom, $urandom});
		color <= color_t'($urandom);
		layer_num <= 1'($urandom_range(1, 0));
		for (int r = 0; r < ROWS; r++)
			mask[r*PIXELS +: PIXELS] <= random_row();
		@(posedge clk);
		math_start <= 1'b0;
		@(negedge clk);
		check_flag("all_finish", 1'b0, all_finish);
	endtask

	task automatic fill_row(input int r);
		int n;
		cur_row = r;
		exp_addr = expected_addr(vertices, layer_num, r);
		// contents of a word the SRAM has not held before
		fill_word = random_word();
		reads = 0;
		writes = 0;
		n = 0;
		@(posedge clk);
		fill_start <= 1'b1;
		while (!fill_done && n < 8)
		begin
			@(posedge clk);
			// stray strobe while the row is busy
			fill_start <= (n == 1);
			@(negedge clk);
			n++;
			check_flag("fill_done", n == 4, fill_done);
		end
		if (!fill_done)
			note_failure($sformatf("row %0d never raised fill_done", r));
		@(negedge clk);
		check_flag("fill_done", 1'b0, fill_done);
		check_flag("all_finish", r == ROWS - 1, all_finish);
		if (reads != 1 || writes != 1)
			note_failure($sformatf("row %0d saw %0d reads and %0d writes", r, reads, writes));
	endtask

	// strobes after the last row must not touch the SRAM
	task automatic poke_finished();
		reads = 0;
		writes = 0;
		repeat (2)
		begin
			@(posedge clk);
			fill_start <= 1'b1;
			@(posedge clk);
			fill_start <= 1'b0;
		end
		repeat (3) @(negedge clk);
		check_flag("all_finish", 1'b1, all_finish);
		if (reads != 0 || writes != 0)
			note_failure("SRAM was accessed after all rows were finished");
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired, the fill stage stopped making progress");
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		n_rst = 1'b0;
		math_start = 1'b0;
		fill_start = 1'b0;
		layer_num = 1'b0;
		vertices = '0;
		color = '0;
		mask = '0;
		read_data = '0;
		errors = 0;
		checks = 0;
		void'($urandom(32'hac8f));
		repeat (3) @(posedge clk);
		n_rst <= 1'b1;
		repeat (2)
		begin
			@(negedge clk);
			check_idle();
		end
		for (int t = 0; t < TRIS; t++)
		begin
			start_triangle();
			for (int r = 0; r < ROWS; r++)
				fill_row(r);
			poke_finished();
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end
endmodule

//--- gfx_fill.f
+incdir+sim
src/gfx_pkg.sv
src/sram_pkg.sv
src/sram_if.sv
src/bbox_corner.sv
src/row_address.sv
src/span_fill.sv
src/gfx_fill_top.sv
sim/tb_gfx_fill.sv
